/* Bender.yml */
package:
  name: apu_sound

sources:
  - files:
      - hw/apu_reg_pkg.sv
      - hw/apu_audio_pkg.sv
      - hw/apu_control.sv
      - hw/apu_channel.sv
      - hw/apu_mixer.sv
      - hw/apu_top.sv
  - target: test
    files:
      - tests/apu_asserts.sv
      - tests/apu_checker.sv
      - tests/apu_tb.sv

/* hw/apu_audio_pkg.sv */
package apu_audio_pkg;

	// one channel output level
	typedef logic [3:0] sample_t;

	typedef logic [2:0] master_vol_t;

	// sum of up to four channels on one side, max 60
	typedef logic [5:0] sum_t;

	// master volume plus one, 1..8
	typedef logic [3:0] gain_t;

	typedef logic [8:0] mix_t;     // side output, max 60 * 8

	typedef logic [10:0] period_t;

	localparam period_t PERIOD_MAX = 11'd2047;  // counter reloads past this

	localparam int SIDE_CHANNELS = 4;  // mixer inputs per side

endpackage

/* hw/apu_channel.sv */
`timescale 1ns/10ps

module apu_channel
	import apu_reg_pkg::*;
	import apu_audio_pkg::*;
(
	input  logic      apuv_4mhz,
	input  logic      rst,
	input  logic      apu_reset,
	input  logic      wr,
	input  chan_reg_t reg_sel,
	input  reg_data_t reg_wdata,
	input  logic      tick_1mhz,
	input  logic      frame_tick,
	output sample_t   sample,
	output logic      active
);

	duty_t      duty;
	sample_t    volume;
	period_t    period;
	logic       len_en;
	len_field_t len_field;
	period_t    period_cnt;
	logic [2:0] duty_step;    // one of 8
	logic [6:0] len_cnt;      // 1..64 after trigger
	logic [7:0] duty_wave;
	logic       trigger;
	period_t    trig_period;

	assign trigger     = wr && (reg_sel == CH_REG_PERIOD_HI) && reg_wdata[TRIG_BIT];
	assign trig_period = {reg_wdata[PER_HI_LSB +: 3], period[7:0]};  // includes new high bits

	always_ff @(posedge apuv_4mhz) begin
		if (rst || apu_reset) begin
			duty      <= '0;
			volume    <= '0;
			period    <= '0;
			len_en    <= 1'b0;
			len_field <= '0;
		end else if (wr) begin
			case (reg_sel)
				CH_REG_DUTY_LEN: begin
					duty      <= reg_wdata[DUTY_LSB +: $bits(duty_t)];
					len_field <= reg_wdata[LEN_LSB +: $bits(len_field_t)];
				end
				CH_REG_VOLUME:    volume <= reg_wdata[VOL_LSB +: $bits(sample_t)];
				CH_REG_PERIOD_LO: period[7:0] <= reg_wdata;
				CH_REG_PERIOD_HI: begin
					period[10:8] <= reg_wdata[PER_HI_LSB +: 3];
					len_en       <= reg_wdata[LEN_EN_BIT];
				end
				default: ;
			endcase
		end
	end

	// sequencer and length counter
	always_ff @(posedge apuv_4mhz) begin
		if (rst || apu_reset) begin
			active     <= 1'b0;
			period_cnt <= '0;
			duty_step  <= '0;
			len_cnt    <= '0;
		end else if (trigger) begin
			active     <= 1'b1;
			period_cnt <= trig_period;
			duty_step  <= '0;
			len_cnt    <= 7'd64 - 7'(len_field);
		end else begin
			if (tick_1mhz && active) begin
				if (period_cnt == PERIOD_MAX) begin
					period_cnt <= period;
					duty_step  <= duty_step + 3'd1;
				end else
					period_cnt <= period_cnt + 11'd1;
			end
			if (frame_tick && len_en && len_cnt != '0)
				len_cnt <= len_cnt - 7'd1;
			if (len_en && len_cnt == '0)
				active <= 1'b0;  // one cycle after reaching zero
		end
	end

	always_comb begin
		case (duty)
			2'd0:    duty_wave = 8'b0000_0001;  // 12.5%
			2'd1:    duty_wave = 8'b1000_0001;  // 25%
			2'd2:    duty_wave = 8'b1000_0111;  // 50%
			default: duty_wave = 8'b0111_1110;  // 75%
		endcase
	end

	assign sample = (active && duty_wave[duty_step]) ? volume : '0;

endmodule

/* hw/apu_control.sv */
`timescale 1ns/10ps

module apu_control
	import apu_reg_pkg::*;
	import apu_audio_pkg::*;
#(
	parameter int FRAME_DIV = 16384
) (
	input  logic                    apuv_4mhz,
	input  logic                    rst,
	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	input  reg_addr_t               addr,
	input  reg_data_t               wdata,
	input  logic [NUM_CHANNELS-1:0] chan_active,
	output reg_data_t               rdata,
	output logic [NUM_CHANNELS-1:0] chan_wr,
	output chan_reg_t               reg_sel,
	output reg_data_t               reg_wdata,
	output logic                    tick_1mhz,
	output logic                    frame_tick,
	output logic                    apu_reset,
	output reg_data_t               pan,
	output master_vol_t             master_left,
	output master_vol_t             master_right
);

	localparam int FRAME_W = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

	typedef enum logic [1:0] {
		OFF,
		WAKE,
		ON
	} pwr_state_t;

	pwr_state_t         state;
	reg_data_t          nr50;
	reg_data_t          nr51;
	reg_data_t          nr52_rd;
	logic               powered;
	logic               wr_ok;
	logic               nr52_wr;
	logic               pwr_on_wr;
	logic               pwr_off_wr;
	logic               in_ch;     // address inside the channel window
	reg_addr_t          ch_off;
	logic [1:0]         div_cnt;
	logic [FRAME_W-1:0] frame_cnt;

	assign powered    = (state != OFF);
	assign apu_reset  = (state == OFF);
	assign wr_ok      = cpu_wr && powered;  // only 0x26 is writable while off
	assign nr52_wr    = cpu_wr && (addr == ADDR_NR52);
	assign pwr_on_wr  = nr52_wr && wdata[NR52_POWER_BIT];
	assign pwr_off_wr = nr52_wr && !wdata[NR52_POWER_BIT];

	// channel window decode
	assign ch_off = addr - ADDR_CH_BASE;
	assign in_ch  = (addr >= ADDR_CH_BASE) &&
	                (addr < ADDR_CH_BASE + reg_addr_t'(4 * NUM_CHANNELS));

	always_comb begin
		for (int n = 0; n < NUM_CHANNELS; n++)
			chan_wr[n] = wr_ok && in_ch && (ch_off[7:2] == 6'(n));
	end

	assign reg_sel   = ch_off[1:0];
	assign reg_wdata = wdata;

	always_ff @(posedge apuv_4mhz) begin
		if (rst)
			state <= OFF;
		else begin
			case (state)
				OFF:     if (pwr_on_wr) state <= WAKE;
				WAKE:    state <= pwr_off_wr ? OFF : ON;  // dividers restart here
				ON:      if (pwr_off_wr) state <= OFF;
				default: state <= OFF;
			endcase
		end
	end

	// master volume and panning, cleared by power off
	always_ff @(posedge apuv_4mhz) begin
		if (rst || pwr_off_wr) begin
			nr50 <= '0;
			nr51 <= '0;
		end else if (wr_ok) begin
			if (addr == ADDR_NR50)
				nr50 <= wdata;
			if (addr == ADDR_NR51)
				nr51 <= wdata;
		end
	end

	assign pan          = nr51;
	assign master_left  = nr50[NR50_LEFT_LSB +: $bits(master_vol_t)];
	assign master_right = nr50[NR50_RIGHT_LSB +: $bits(master_vol_t)];

	always_comb begin
		nr52_rd                      = '0;
		nr52_rd[NR52_POWER_BIT]      = powered;
		nr52_rd[NUM_CHANNELS-1:0]    = chan_active;
	end

	always_ff @(posedge apuv_4mhz) begin
		if (rst)
			rdata <= '0;
		else if (cpu_rd) begin
			case (addr)
				ADDR_NR50: rdata <= nr50;
				ADDR_NR51: rdata <= nr51;
				ADDR_NR52: rdata <= nr52_rd;
				default:   rdata <= 8'hFF;  // channel regs read back as ff
			endcase
		end
	end

	// clock enables, both counters stopped until ON
	always_ff @(posedge apuv_4mhz) begin
		if (rst || state != ON) begin
			div_cnt   <= '0;
			frame_cnt <= '0;
		end else begin
			div_cnt   <= div_cnt + 2'd1;
			frame_cnt <= frame_tick ? '0 : frame_cnt + FRAME_W'(1);
		end
	end

	assign tick_1mhz  = (state == ON) && (div_cnt == 2'd3);
	assign frame_tick = (state == ON) && (frame_cnt == FRAME_W'(FRAME_DIV - 1));

endmodule

/* hw/apu_mixer.sv */
`timescale 1ns/10ps

module apu_mixer
	import apu_audio_pkg::*;
(
	input  logic        apuv_4mhz,
	input  logic        rst,
	input  sample_t     sample0,
	input  sample_t     sample1,
	input  sample_t     sample2,
	input  sample_t     sample3,
	input  logic [7:0]  pan,
	input  master_vol_t master_left,
	input  master_vol_t master_right,
	output mix_t        left_out,
	output mix_t        right_out
);

	sample_t samples [SIDE_CHANNELS];
	sum_t    sum_l;
	sum_t    sum_r;
	gain_t   gain_l;
	gain_t   gain_r;
	mix_t    prod_l;
	mix_t    prod_r;

	assign samples[0] = sample0;
	assign samples[1] = sample1;
	assign samples[2] = sample2;
	assign samples[3] = sample3;

	// low pan nibble feeds left, high nibble right
	always_comb begin
		sum_l = '0;
		sum_r = '0;
		for (int i = 0; i < SIDE_CHANNELS; i++) begin
			if (pan[i])
				sum_l = sum_l + sum_t'(samples[i]);
			if (pan[i + SIDE_CHANNELS])
				sum_r = sum_r + sum_t'(samples[i]);
		end
	end

	assign gain_l = gain_t'(master_left) + gain_t'(1);  // 0..7 maps to x1..x8
	assign gain_r = gain_t'(master_right) + gain_t'(1);
	assign prod_l = mix_t'(sum_l) * mix_t'(gain_l);
	assign prod_r = mix_t'(sum_r) * mix_t'(gain_r);

	always_ff @(posedge apuv_4mhz) begin
		if (rst) begin
			left_out  <= '0;
			right_out <= '0;
		end else begin
			left_out  <= prod_l;
			right_out <= prod_r;
		end
	end

endmodule

/* hw/apu_reg_pkg.sv */
package apu_reg_pkg;

	typedef logic [7:0] reg_addr_t;  // low byte of the ff00 page
	typedef logic [7:0] reg_data_t;
	typedef logic [1:0] chan_reg_t;  // register inside one channel
	typedef logic [1:0] duty_t;
	typedef logic [5:0] len_field_t;

	localparam int NUM_CHANNELS = 4;

	localparam reg_addr_t ADDR_CH_BASE = 8'h10;  // channel n at base + 4n
	localparam reg_addr_t ADDR_NR50    = 8'h24;  // master volume
	localparam reg_addr_t ADDR_NR51    = 8'h25;  // panning, low nibble left
	localparam reg_addr_t ADDR_NR52    = 8'h26;  // power and status

	localparam int NR50_LEFT_LSB  = 0;
	localparam int NR50_RIGHT_LSB = 4;
	localparam int NR51_RIGHT_LSB = 4;
	localparam int NR52_POWER_BIT = 7;

	// channel register map
	localparam chan_reg_t CH_REG_DUTY_LEN  = 2'd0;
	localparam chan_reg_t CH_REG_VOLUME    = 2'd1;
	localparam chan_reg_t CH_REG_PERIOD_LO = 2'd2;
	localparam chan_reg_t CH_REG_PERIOD_HI = 2'd3;

	localparam int DUTY_LSB   = 6;  // reg 0
	localparam int LEN_LSB    = 0;  // reg 0
	localparam int VOL_LSB    = 0;  // reg 1
	localparam int TRIG_BIT   = 7;  // reg 3
	localparam int LEN_EN_BIT = 6;  // reg 3
	localparam int PER_HI_LSB = 0;  // reg 3, three bits

endpackage

/* hw/apu_top.sv */
`timescale 1ns/10ps

module apu_top
	import apu_reg_pkg::*;
	import apu_audio_pkg::*;
#(
	parameter int FRAME_DIV = 16384
) (
	input  logic                    apuv_4mhz,
	input  logic                    rst,
	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	input  reg_addr_t               addr,
	input  reg_data_t               wdata,
	output reg_data_t               rdata,
	output mix_t                    left_out,
	output mix_t                    right_out,
	output logic [NUM_CHANNELS-1:0] chan_active
);

	logic [NUM_CHANNELS-1:0] chan_wr;
	chan_reg_t               reg_sel;
	reg_data_t               reg_wdata;
	logic                    tick_1mhz;
	logic                    frame_tick;
	logic                    apu_reset;
	reg_data_t               pan;
	master_vol_t             master_left;
	master_vol_t             master_right;
	sample_t                 samples [NUM_CHANNELS];

	apu_control #(
		.FRAME_DIV(FRAME_DIV)
	) apu_control_i (
		.apuv_4mhz   (apuv_4mhz),
		.rst         (rst),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.addr        (addr),
		.wdata       (wdata),
		.chan_active (chan_active),
		.rdata       (rdata),
		.chan_wr     (chan_wr),
		.reg_sel     (reg_sel),
		.reg_wdata   (reg_wdata),
		.tick_1mhz   (tick_1mhz),
		.frame_tick  (frame_tick),
		.apu_reset   (apu_reset),
		.pan         (pan),
		.master_left (master_left),
		.master_right(master_right)
	);

	for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_chan
		apu_channel apu_channel_i (
			.apuv_4mhz (apuv_4mhz),
			.rst       (rst),
			.apu_reset (apu_reset),
			.wr        (chan_wr[n]),
			.reg_sel   (reg_sel),
			.reg_wdata (reg_wdata),
			.tick_1mhz (tick_1mhz),
			.frame_tick(frame_tick),
			.sample    (samples[n]),
			.active    (chan_active[n])
		);
	end

	apu_mixer apu_mixer_i (
		.apuv_4mhz   (apuv_4mhz),
		.rst         (rst),
		.sample0     (samples[0]),
		.sample1     (samples[1]),
		.sample2     (samples[2]),
		.sample3     (samples[3]),
		.pan         (pan),
		.master_left (master_left),
		.master_right(master_right),
		.left_out    (left_out),
		.right_out   (right_out)
	);

endmodule

/* tests/apu_asserts.sv */
`timescale 1ns/10ps

module apu_asserts
	import apu_reg_pkg::*;
(
	input logic                    apuv_4mhz,
	input logic                    rst,
	input logic [NUM_CHANNELS-1:0] chan_wr,
	input logic                    tick_1mhz,
	input logic                    apu_reset,
	input reg_data_t               rdata
);

	int failures;

	initial failures = 0;

	chan_wr_onehot: assert property (@(posedge apuv_4mhz) disable iff (rst)
		$onehot0(chan_wr))
		else begin
			failures++;
			$error("chan_wr selects more than one channel");
		end

	// first tick only after wake plus a full divider turn
	tick_after_wake: assert property (@(posedge apuv_4mhz) disable iff (rst)
		tick_1mhz |-> !$past(apu_reset, 1) && !$past(apu_reset, 2) &&
		              !$past(apu_reset, 3) && !$past(apu_reset, 4))
		else begin
			failures++;
			$error("tick_1mhz pulsed before the divider restarted");
		end

	rdata_clear_after_reset: assert property (@(posedge apuv_4mhz)
		rst |=> (rdata == 8'h00))
		else begin
			failures++;
			$error("rdata not zero in the cycle after reset");
		end

endmodule

bind apu_control apu_asserts apu_asserts_i (
	.apuv_4mhz(apuv_4mhz),
	.rst      (rst),
	.chan_wr  (chan_wr),
	.tick_1mhz(tick_1mhz),
	.apu_reset(apu_reset),
	.rdata    (rdata)
);

/* tests/apu_checker.sv */
`timescale 1ns/10ps

module apu_checker
	import apu_reg_pkg::*;
	import apu_audio_pkg::*;
#(
	parameter int FRAME_DIV = 16384
) (
	input  logic                    apuv_4mhz,
	input  logic                    rst,
	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	input  reg_addr_t               addr,
	input  reg_data_t               wdata,
	input  reg_data_t               rdata,
	input  mix_t                    left_out,
	input  mix_t                    right_out,
	input  logic [NUM_CHANNELS-1:0] chan_active,
	output int                      mismatches,
	output int                      frame_ticks
);

	int                      pwr;  // 0 off, 1 wake, 2 on
	int                      div;
	int                      fcnt;
	logic                    valid;
	reg_data_t               nr50;
	reg_data_t               nr51;
	reg_data_t               want_rdata;
	mix_t                    want_left;
	mix_t                    want_right;
	logic [NUM_CHANNELS-1:0] act;
	reg_data_t               creg [NUM_CHANNELS][4];  // raw channel register bytes
	period_t                 pcnt [NUM_CHANNELS];
	logic [2:0]              step [NUM_CHANNELS];
	int                      lcnt [NUM_CHANNELS];

	initial begin
		valid       = 1'b0;
		mismatches  = 0;
		frame_ticks = 0;
	end

	function automatic sample_t chan_level(int n);
		logic [7:0] wave;
		case (creg[n][0][7:6])
			2'd0:    wave = 8'b0000_0001;  // 12.5%
			2'd1:    wave = 8'b1000_0001;
			2'd2:    wave = 8'b1000_0111;
			default: wave = 8'b0111_1110;  // 75%
		endcase
		return (act[n] && wave[step[n]]) ? creg[n][1][3:0] : 4'd0;
	endfunction

	// pan bits lsb..lsb+3 pick the channels of one side
	function automatic mix_t side_level(int lsb, master_vol_t mv);
		int sum;
		sum = 0;
		for (int i = 0; i < NUM_CHANNELS; i++)
			if (nr51[lsb + i])
				sum += chan_level(i);
		return mix_t'(sum * (mv + 1));
	endfunction

	function automatic reg_data_t read_value(reg_addr_t a);
		case (a)
			ADDR_NR50: return nr50;
			ADDR_NR51: return nr51;
			ADDR_NR52: return {pwr != 0, 3'b000, act};
			default:   return 8'hFF;
		endcase
	endfunction

	task automatic clear_chan(int n);
		for (int r = 0; r < 4; r++)
			creg[n][r] = '0;
		act[n]  = 1'b0;
		pcnt[n] = '0;
		step[n] = '0;
		lcnt[n] = 0;
	endtask

	task automatic step_chan(int n, logic tick, logic frame);
		if (tick && act[n]) begin
			if (pcnt[n] == 11'd2047) begin
				pcnt[n] = {creg[n][3][2:0], creg[n][2]};  // reload from period reg
				step[n] = step[n] + 3'd1;
			end else
				pcnt[n] = pcnt[n] + 11'd1;
		end
		if (creg[n][3][6] && lcnt[n] == 0)
			act[n] = 1'b0;
		else if (frame && creg[n][3][6])
			lcnt[n]--;
	endtask

	task automatic write_chan(int n, int r, reg_data_t d);
		creg[n][r] = d;
		if (r == 3 && d[7]) begin  // trigger
			act[n]  = 1'b1;
			pcnt[n] = {d[2:0], creg[n][2]};
			step[n] = '0;
			lcnt[n] = 64 - int'(creg[n][0][5:0]);
		end
	endtask

	task automatic compare(string name, logic [8:0] got, logic [8:0] want);
		if (got !== want) begin
			mismatches++;
			$display("Mismatch at %0t: %s is %h, model expects %h", $time, name, got, want);
		end
	endtask

	always @(posedge apuv_4mhz) begin : model_step
		logic tick;
		logic frame;
		if (rst) begin
			pwr        = 0;
			div        = 0;
			fcnt       = 0;
			nr50       = '0;
			nr51       = '0;
			want_rdata = '0;
			want_left  = '0;
			want_right = '0;
			for (int n = 0; n < NUM_CHANNELS; n++)
				clear_chan(n);
			valid = 1'b1;
		end else begin
			tick  = (pwr == 2) && (div == 3);
			frame = (pwr == 2) && (fcnt == FRAME_DIV - 1);
			if (frame)
				frame_ticks++;
			want_left  = side_level(0, nr50[2:0]);   // from values before the edge
			want_right = side_level(4, nr50[6:4]);
			if (cpu_rd)
				want_rdata = read_value(addr);
			for (int n = 0; n < NUM_CHANNELS; n++) begin
				if (pwr == 0)
					clear_chan(n);
				else
					step_chan(n, tick, frame);
			end
			if (cpu_wr && pwr != 0) begin
				if (addr == ADDR_NR50)
					nr50 = wdata;
				if (addr == ADDR_NR51)
					nr51 = wdata;
				if (addr >= 8'h10 && addr < 8'h20)
					write_chan((addr - 8'h10) >> 2, addr[1:0], wdata);
			end
			if (pwr != 2) begin
				div  = 0;
				fcnt = 0;
			end else begin
				div  = (div + 1) % 4;
				fcnt = frame ? 0 : fcnt + 1;
			end
			if (cpu_wr && addr == ADDR_NR52 && !wdata[7]) begin
				pwr  = 0;
				nr50 = '0;
				nr51 = '0;
			end else if (pwr == 1)
				pwr = 2;  // wake lasts one cycle
			else if (pwr == 0 && cpu_wr && addr == ADDR_NR52)
				pwr = 1;
		end
	end

	always @(negedge apuv_4mhz) begin
		if (valid) begin
			compare("rdata", rdata, want_rdata);
			compare("left_out", left_out, want_left);
			compare("right_out", right_out, want_right);
			compare("chan_active", chan_active, act);
		end
	end

endmodule

/* tests/apu_tb.sv */
`timescale 1ns/10ps

module apu_tb
	import apu_reg_pkg::*;
	import apu_audio_pkg::*;
();

	localparam int FRAME_DIV = 64;  // length tick every 64 clocks

	logic                    apuv_4mhz;
	logic                    rst;
	logic                    cpu_rd;
	logic                    cpu_wr;
	reg_addr_t               addr;
	reg_data_t               wdata;
	reg_data_t               rdata;
	mix_t                    left_out;
	mix_t                    right_out;
	logic [NUM_CHANNELS-1:0] chan_active;
	int                      mismatches;
	int                      frame_ticks;
	int                      errors;
	int                      err_mark;
	int                      passed;
	int                      failed;
	logic [31:0]             seed;

	apu_top #(.FRAME_DIV(FRAME_DIV)) apu_top_i (.*);

	apu_checker #(.FRAME_DIV(FRAME_DIV)) apu_checker_i (.*);

	initial begin
		apuv_4mhz = 1'b0;
		forever #50 apuv_4mhz = ~apuv_4mhz;
	end

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic reg_data_t rand_byte();
		seed = xorshift(seed);
		return seed[7:0];
	endfunction

	// own checks, model mismatches and bound assertion failures
	function automatic int error_total();
		return errors + mismatches + apu_top_i.apu_control_i.apu_asserts_i.failures;
	endfunction

	// bus tasks start and end 5 ns after a rising edge
	task automatic write_reg(reg_addr_t a, reg_data_t d);
		cpu_wr = 1'b1;
		addr   = a;
		wdata  = d;
		@(posedge apuv_4mhz);
		#5;
		cpu_wr = 1'b0;
	endtask

	task automatic read_reg(reg_addr_t a, output reg_data_t d);
		cpu_rd = 1'b1;
		addr   = a;
		@(posedge apuv_4mhz);
		#5;
		cpu_rd = 1'b0;
		d      = rdata;  // registered on the edge just passed
	endtask

	task automatic check_read(reg_addr_t a, reg_data_t want);
		reg_data_t got;
		read_reg(a, got);
		if (got !== want) begin
			errors++;
			$display("Mismatch at %0t: read of %h gave %h, expected %h", $time, a, got, want);
		end
	endtask

	task automatic wait_cycles(int n);
		repeat (n) begin
			@(posedge apuv_4mhz);
			#5;
		end
	endtask

	task automatic report_test(string name);
		int errs;
		errs = error_total() - err_mark;
		if (errs == 0) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errs);
		end
		err_mark = error_total();
	endtask

	initial begin
		reg_data_t  d;
		reg_addr_t  base;
		logic [5:0] len_f;
		int         ticks;
		int         cnt;
		logic       heard;
		rst      = 1'b1;
		cpu_rd   = 1'b0;
		cpu_wr   = 1'b0;
		addr     = '0;
		wdata    = '0;
		seed     = 32'h7771;
		errors   = 0;
		err_mark = 0;
		passed   = 0;
		failed   = 0;
		repeat (10) @(posedge apuv_4mhz);
		#5;
		rst = 1'b0;

		check_read(ADDR_NR50, 8'h00);
		check_read(ADDR_NR51, 8'h00);
		check_read(ADDR_NR52, 8'h00);
		if (left_out !== '0 || right_out !== '0 || chan_active !== '0) begin
			errors++;
			$display("Mismatch at %0t: outputs not idle after reset", $time);
		end
		report_test("reset values");

		write_reg(ADDR_NR52, 8'h80);
		for (int i = 0; i < 8; i++) begin
			d = rand_byte();
			write_reg(ADDR_NR50, d);
			check_read(ADDR_NR50, d);
			d = rand_byte();
			write_reg(ADDR_NR51, d);
			check_read(ADDR_NR51, d);
		end
		for (int a = 0; a < 4 * NUM_CHANNELS; a++)
			check_read(reg_addr_t'(ADDR_CH_BASE + a), 8'hFF);
		report_test("register readback");

		write_reg(8'h13, 8'h87);  // trigger channel 0, no length
		check_read(ADDR_NR52, 8'h81);
		write_reg(ADDR_NR52, 8'h00);
		wait_cycles(2);
		check_read(ADDR_NR50, 8'h00);
		check_read(ADDR_NR51, 8'h00);
		check_read(ADDR_NR52, 8'h00);
		write_reg(ADDR_NR50, rand_byte() | 8'h01);
		write_reg(ADDR_NR51, rand_byte() | 8'h01);
		for (int r = 0; r < 3; r++)
			write_reg(reg_addr_t'(ADDR_CH_BASE + r), rand_byte());
		write_reg(8'h13, 8'h87);
		wait_cycles(2);
		check_read(ADDR_NR50, 8'h00);
		check_read(ADDR_NR51, 8'h00);
		check_read(ADDR_NR52, 8'h00);
		if (chan_active !== '0) begin
			errors++;
			$display("Mismatch at %0t: channels active while power is off", $time);
		end
		report_test("power off");

		write_reg(ADDR_NR52, 8'h80);
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			base  = reg_addr_t'(ADDR_CH_BASE + 4 * n);
			d     = rand_byte();
			len_f = d[5:0];
			write_reg(base, d);
			write_reg(base + 8'd1, 8'h0F);
			write_reg(base + 8'd3, 8'hC7);  // trigger with length enable
			ticks = frame_ticks;
			check_read(ADDR_NR52, reg_data_t'(8'h80 | (1 << n)));
			cnt = 0;
			while (chan_active[n] && cnt < 5000) begin
				@(posedge apuv_4mhz);
				#5;
				cnt++;
			end
			if (chan_active[n]) begin
				errors++;
				$display("timeout: channel %0d still active after %0d cycles", n, cnt);
			end else if (frame_ticks - ticks != 64 - int'(len_f)) begin
				errors++;
				$display("Mismatch at %0t: channel %0d stopped after %0d frame ticks, expected %0d",
				         $time, n, frame_ticks - ticks, 64 - int'(len_f));
			end
		end
		report_test("length counter");

		for (int n = 0; n < NUM_CHANNELS; n++) begin
			base = reg_addr_t'(ADDR_CH_BASE + 4 * n);
			d    = rand_byte();
			write_reg(base, d & 8'hC0);
			write_reg(base + 8'd1, {4'h0, d[3:0] | 4'h1});
			write_reg(base + 8'd2, 8'hD0 | rand_byte());  // periods 2000 and up
			write_reg(base + 8'd3, 8'h87);
		end
		heard = 1'b0;
		for (int k = 0; k < 8; k++) begin
			write_reg(ADDR_NR51, rand_byte());
			write_reg(ADDR_NR50, rand_byte());
			repeat (500) begin
				@(posedge apuv_4mhz);
				#5;
				if (left_out != '0 || right_out != '0)
					heard = 1'b1;
			end
		end
		if (!heard) begin
			errors++;
			$display("stereo outputs stayed at zero for the whole mixing run");
		end
		report_test("mixing");

		$display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, mismatches);
		if (failed == 0 && error_total() == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* verilog.f */
hw/apu_reg_pkg.sv
hw/apu_audio_pkg.sv
hw/apu_control.sv
hw/apu_channel.sv
hw/apu_mixer.sv
hw/apu_top.sv
tests/apu_asserts.sv
tests/apu_checker.sv
tests/apu_tb.sv
